/* src/mos6502_isa_pkg.sv */
/*
 * Opcode table for the kept subset of the 6502 instruction set.
 * Accumulator shifts and flag opcodes are also decoded from the field view,
 * so the union layout must stay aaa, bbb, cc from the MSB down.
 */
package mos6502_isa_pkg;

    // status register bit positions
    localparam int P_CARRY = 0;

    // implied register increment and decrement
    localparam logic [7:0] OP_INX     = 8'hE8;
    localparam logic [7:0] OP_INY     = 8'hC8;
    localparam logic [7:0] OP_DEX     = 8'hCA;
    localparam logic [7:0] OP_DEY     = 8'h88;

    // accumulator shifts
    localparam logic [7:0] OP_ASL_A   = 8'h0A;
    localparam logic [7:0] OP_ROL_A   = 8'h2A;
    localparam logic [7:0] OP_LSR_A   = 8'h4A;
    localparam logic [7:0] OP_ROR_A   = 8'h6A;

    // flag set and clear
    localparam logic [7:0] OP_CLC     = 8'h18;
    localparam logic [7:0] OP_SEC     = 8'h38;
    localparam logic [7:0] OP_CLI     = 8'h58;
    localparam logic [7:0] OP_SEI     = 8'h78;

    // register transfers
    localparam logic [7:0] OP_TAX     = 8'hAA;
    localparam logic [7:0] OP_TAY     = 8'hA8;
    localparam logic [7:0] OP_TXA     = 8'h8A;
    localparam logic [7:0] OP_TYA     = 8'h98;
    localparam logic [7:0] OP_TXS     = 8'h9A;
    localparam logic [7:0] OP_TSX     = 8'hBA;

    localparam logic [7:0] OP_NOP     = 8'hEA;

    // immediate and absolute memory access
    localparam logic [7:0] OP_LDA_IMM = 8'hA9;
    localparam logic [7:0] OP_LDX_IMM = 8'hA2;
    localparam logic [7:0] OP_LDY_IMM = 8'hA0;
    localparam logic [7:0] OP_LDA_ABS = 8'hAD;
    localparam logic [7:0] OP_LDX_ABS = 8'hAE;
    localparam logic [7:0] OP_LDY_ABS = 8'hAC;
    localparam logic [7:0] OP_STA_ABS = 8'h8D;

    // classic aaa bbb cc split of the opcode byte
    typedef struct packed {
        logic [2:0] aaa;
        logic [2:0] bbb;
        logic [1:0] cc;
    } opcode_fields_t;

    typedef union packed {
        logic [7:0]     raw;
        opcode_fields_t fld;
    } opcode_u;

endpackage

/* src/mos6502_timing_pkg.sv */
/*
 * Timing state encoding and bus levels.
 * Only T0 to T3 are named; unknown opcodes run through all 16 states.
 */
package mos6502_timing_pkg;

    localparam int TCU_W = 4;

    // cycle numbers of the instruction sequence
    localparam logic [TCU_W-1:0] T0 = TCU_W'(0);
    localparam logic [TCU_W-1:0] T1 = TCU_W'(1);
    localparam logic [TCU_W-1:0] T2 = TCU_W'(2);
    localparam logic [TCU_W-1:0] T3 = TCU_W'(3);

    // R/W pin, high for a read as on the real part
    localparam logic RW_READ  = 1'b1;
    localparam logic RW_WRITE = 1'b0;

endpackage

/* src/opcode_classifier.sv */
/*
 * Sorts the instruction register into classes and register selects.
 * Purely combinational; opcodes outside the kept set raise no class.
 */
`timescale 1ns/100ps

module opcode_classifier
    import mos6502_isa_pkg::*;
(
    input  logic [7:0] i_ir,
    output logic o_known,
    output logic o_cls_incdec, o_cls_shift, o_cls_flag, o_cls_load_imm,
    output logic o_cls_abs, o_abs_store, o_cls_xfer, o_cls_nop,
    output logic o_src_x, o_src_y, o_src_ac, o_src_s,
    output logic o_dst_x, o_dst_y, o_dst_ac, o_dst_s,
    output logic o_sets_nz, o_dec, o_shift_right, o_rotate, o_flag_i
);
    opcode_u ir_u;

    assign ir_u.raw = i_ir;

    // raw compares
    assign o_cls_incdec   = ir_u.raw inside {OP_INX, OP_INY, OP_DEX, OP_DEY};
    assign o_cls_load_imm = ir_u.raw inside {OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM};
    assign o_cls_abs      = ir_u.raw inside {OP_LDA_ABS, OP_LDX_ABS, OP_LDY_ABS, OP_STA_ABS};
    assign o_abs_store    = (ir_u.raw == OP_STA_ABS);
    assign o_cls_xfer     = ir_u.raw inside {OP_TAX, OP_TAY, OP_TXA, OP_TYA, OP_TXS, OP_TSX};
    assign o_cls_nop      = (ir_u.raw == OP_NOP);
    assign o_dec          = ir_u.raw inside {OP_DEX, OP_DEY};

    // accumulator shifts live at bbb=010 cc=10, flags at bbb=110 cc=00
    assign o_cls_shift   = (ir_u.fld.bbb == 3'b010) && (ir_u.fld.cc == 2'b10) && !ir_u.fld.aaa[2];
    assign o_cls_flag    = (ir_u.fld.bbb == 3'b110) && (ir_u.fld.cc == 2'b00) && !ir_u.fld.aaa[2];
    assign o_shift_right = o_cls_shift && ir_u.fld.aaa[1];
    assign o_rotate      = o_cls_shift && ir_u.fld.aaa[0];
    assign o_flag_i      = o_cls_flag && ir_u.fld.aaa[1];

    // register selects
    assign o_src_x  = ir_u.raw inside {OP_INX, OP_DEX, OP_TXA, OP_TXS};
    assign o_src_y  = ir_u.raw inside {OP_INY, OP_DEY, OP_TYA};
    assign o_src_ac = o_cls_shift || (ir_u.raw inside {OP_TAX, OP_TAY, OP_STA_ABS});
    assign o_src_s  = (ir_u.raw == OP_TSX);
    assign o_dst_x  = ir_u.raw inside {OP_INX, OP_DEX, OP_TAX, OP_TSX, OP_LDX_IMM, OP_LDX_ABS};
    assign o_dst_y  = ir_u.raw inside {OP_INY, OP_DEY, OP_TAY, OP_LDY_IMM, OP_LDY_ABS};
    assign o_dst_ac = o_cls_shift || (ir_u.raw inside {OP_TXA, OP_TYA, OP_LDA_IMM, OP_LDA_ABS});
    assign o_dst_s  = (ir_u.raw == OP_TXS);

    // TXS leaves Z and N alone
    assign o_sets_nz = o_cls_xfer && (ir_u.raw != OP_TXS);

    assign o_known = o_cls_incdec | o_cls_shift | o_cls_flag | o_cls_load_imm
                   | o_cls_abs | o_cls_xfer | o_cls_nop;

    // at most one class per opcode
    always_comb
    begin
        assert final ($onehot0({o_cls_incdec, o_cls_shift, o_cls_flag, o_cls_load_imm,
                                o_cls_abs, o_cls_xfer, o_cls_nop}))
            else $error("more than one instruction class for opcode %h", i_ir);
    end

endmodule

/* src/timing_counter.sv */
/*
 * Instruction timing state, restarted at T0 on the last cycle.
 * Unknown opcodes let the state count freely and wrap modulo 16.
 */
`timescale 1ns/100ps

module timing_counter
    import mos6502_timing_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_arst_n,
    input  logic             i_known,
    input  logic             i_cls_abs,
    output logic [TCU_W-1:0] o_tcu
);
    logic last_cycle;

    // absolute ends at T3, every other known class at T1
    assign last_cycle = i_cls_abs ? (o_tcu == T3) : (i_known && (o_tcu == T1));

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            o_tcu <= T0;
        else if (last_cycle)
            o_tcu <= T0;
        else
            o_tcu <= o_tcu + TCU_W'(1);
    end

    // known instructions never run past the absolute sequence
    assert property (@(posedge i_clk) disable iff (!i_arst_n) i_known |-> (o_tcu <= T3))
        else $error("timing state %0d beyond T3 for a known opcode", o_tcu);

endmodule

/* src/address_bus_control.sv */
/*
 * Address bus sources, PC hold and increment, and the R/W level.
 * The only write cycle is T3 of an absolute store.
 */
`timescale 1ns/100ps

module address_bus_control
    import mos6502_timing_pkg::*;
(
    input  logic [TCU_W-1:0] i_tcu,
    input  logic i_known,
    input  logic i_cls_load_imm,
    input  logic i_cls_abs,
    input  logic i_abs_store,
    output logic o_pcl_adl, o_pch_adh, o_adl_abl, o_adh_abh,
    output logic o_pcl_pcl, o_pch_pch, o_i_pc,
    output logic o_add_adl, o_dl_adh,
    output logic o_rw
);
    logic pc_bus;
    logic abs_t3;

    // fetch and operand cycles address through the PC
    assign pc_bus = (i_tcu == T0) || (i_known && ((i_tcu == T1) || (i_tcu == T2)));
    assign abs_t3 = i_cls_abs && (i_tcu == T3);

    assign o_pcl_adl = pc_bus;
    assign o_pch_adh = pc_bus;
    assign o_adl_abl = pc_bus || abs_t3;
    assign o_adh_abh = pc_bus || abs_t3;

    // PC recirculates through the incrementer, also on the last absolute cycle
    assign o_pcl_pcl = pc_bus || abs_t3;
    assign o_pch_pch = pc_bus || abs_t3;
    assign o_i_pc    = (i_tcu == T0) || ((i_tcu == T1) && (i_cls_load_imm || i_cls_abs))
                    || abs_t3;

    // effective address: low byte from the adder, high byte from the data latch
    assign o_add_adl = abs_t3;
    assign o_dl_adh  = abs_t3;

    assign o_rw = (abs_t3 && i_abs_store) ? RW_WRITE : RW_READ;

    always_comb
    begin
        assert final ((o_rw == RW_READ) || (i_tcu == T3))
            else $error("write strobe outside T3 at state %0d", i_tcu);
    end

endmodule

/* src/register_bus_control.sv */
/*
 * SB and DB transfers, register loads and status flag loads.
 * Adder results of INC/DEC and shifts are written back at the next T0,
 * while the instruction register still holds the finishing opcode.
 */
`timescale 1ns/100ps

module register_bus_control
    import mos6502_timing_pkg::*;
(
    input  logic [TCU_W-1:0] i_tcu,
    input  logic i_cls_incdec, i_cls_shift, i_cls_flag, i_cls_load_imm,
    input  logic i_cls_xfer, i_cls_abs, i_abs_store,
    input  logic i_src_x, i_src_y, i_src_ac, i_src_s,
    input  logic i_dst_x, i_dst_y, i_dst_ac, i_dst_s,
    input  logic i_sets_nz, i_shift_right, i_flag_i,
    output logic o_x_sb, o_y_sb, o_ac_sb, o_s_sb,
    output logic o_sb_x, o_sb_y, o_sb_ac, o_sb_s,
    output logic o_sb_db, o_dl_db, o_ac_db,
    output logic o_add_sb_7, o_add_sb_0_6,
    output logic o_dbz_z, o_db7_n, o_ir5_c, o_ir5_i
);
    logic t0, t1, t2, t3;
    logic write_back;
    logic abs_load;
    logic src_drive;
    logic dst_load;
    logic zn_load;

    assign t0 = (i_tcu == T0);
    assign t1 = (i_tcu == T1);
    assign t2 = (i_tcu == T2);
    assign t3 = (i_tcu == T3);

    assign write_back = t0 && (i_cls_incdec || i_cls_shift);
    assign abs_load   = t3 && i_cls_abs && !i_abs_store;
    assign src_drive  = t1 && (i_cls_incdec || i_cls_shift || i_cls_xfer);
    assign dst_load   = write_back || (t1 && (i_cls_xfer || i_cls_load_imm)) || abs_load;
    assign zn_load    = write_back || (t1 && ((i_cls_xfer && i_sets_nz) || i_cls_load_imm))
                     || abs_load;

    // source register onto SB
    assign o_x_sb  = src_drive && i_src_x;
    assign o_y_sb  = src_drive && i_src_y;
    assign o_ac_sb = src_drive && i_src_ac;
    assign o_s_sb  = src_drive && i_src_s;

    // SB into the destination register
    assign o_sb_x  = dst_load && i_dst_x;
    assign o_sb_y  = dst_load && i_dst_y;
    assign o_sb_ac = dst_load && i_dst_ac;
    assign o_sb_s  = dst_load && i_dst_s;

    // left shifts also feed the accumulator to the adder's DB input
    assign o_sb_db = zn_load || (t1 && i_cls_shift && !i_shift_right);
    assign o_dl_db = (t1 && (i_cls_load_imm || i_cls_abs)) || abs_load;
    assign o_ac_db = t3 && i_cls_abs && i_abs_store;

    // adder result onto SB for write-back, and held through T2 of absolute
    assign o_add_sb_7   = write_back || (t2 && i_cls_abs);
    assign o_add_sb_0_6 = write_back || (t2 && i_cls_abs);

    assign o_dbz_z = zn_load;
    assign o_db7_n = zn_load;

    // IR bit 5 is the new flag value
    assign o_ir5_c = t1 && i_cls_flag && !i_flag_i;
    assign o_ir5_i = t1 && i_cls_flag && i_flag_i;

endmodule

/* src/alu_control.sv */
/*
 * Adder input selects, operation select and carry control.
 * DB floats high when nothing drives it, so it reads as 8'hFF.
 */
`timescale 1ns/100ps

module alu_control
    import mos6502_isa_pkg::*;
    import mos6502_timing_pkg::*;
(
    input  logic [TCU_W-1:0] i_tcu,
    input  logic [7:0] i_p,
    input  logic i_cls_incdec, i_cls_shift, i_cls_abs,
    input  logic i_dec, i_shift_right, i_rotate,
    output logic o_sb_add, o_db_add, o_db_n_add, o_0_add,
    output logic o_1_addc, o_sums, o_srs, o_acr_c
);
    always_comb
    begin
        o_sb_add   = 1'b0;
        o_db_add   = 1'b0;
        o_db_n_add = 1'b0;
        o_0_add    = 1'b0;
        o_1_addc   = 1'b0;
        o_sums     = 1'b0;
        o_srs      = 1'b0;
        o_acr_c    = 1'b0;

        if (i_tcu == T1)
        begin
            if (i_cls_incdec)
            begin
                // +1 is reg + ~FF + carry, -1 is reg + FF
                o_sb_add   = 1'b1;
                o_sums     = 1'b1;
                o_db_n_add = !i_dec;
                o_db_add   = i_dec;
                o_1_addc   = !i_dec;
            end
            if (i_cls_shift)
            begin
                o_sb_add = 1'b1;
                o_acr_c  = 1'b1;
                o_srs    = i_shift_right;
                // ASL/ROL double the accumulator
                o_db_add = !i_shift_right;
                o_sums   = !i_shift_right;
                o_1_addc = i_rotate && i_p[P_CARRY];
            end
            if (i_cls_abs)
            begin
                // low address byte passes through as 0 + DB
                o_0_add  = 1'b1;
                o_db_add = 1'b1;
                o_sums   = 1'b1;
            end
        end
        else if ((i_tcu == T2) && i_cls_abs)
        begin
            // SB + 0 keeps the low address byte in the adder
            o_sb_add   = 1'b1;
            o_db_n_add = 1'b1;
            o_sums     = 1'b1;
        end
    end

endmodule

/* src/decode_rom_top.sv */
/*
 * Decode ROM top level: classifier, timing counter and control decoders.
 * i_ir must be valid from T1; at T0 it still holds the finishing opcode.
 * All strobes are active high and combinational from state, IR and P.
 */
`timescale 1ns/100ps

module decode_rom_top
    import mos6502_timing_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_arst_n,
    input  logic [7:0]       i_ir,
    input  logic [7:0]       i_p,
    output logic [TCU_W-1:0] o_tcu,
    // address bus and program counter
    output logic o_pcl_adl, o_pch_adh, o_adl_abl, o_adh_abh,
    output logic o_pcl_pcl, o_pch_pch, o_i_pc,
    output logic o_add_adl, o_dl_adh,
    output logic o_rw,
    // register buses and flags
    output logic o_x_sb, o_y_sb, o_ac_sb, o_s_sb,
    output logic o_sb_x, o_sb_y, o_sb_ac, o_sb_s,
    output logic o_sb_db, o_dl_db, o_ac_db,
    output logic o_add_sb_7, o_add_sb_0_6,
    output logic o_dbz_z, o_db7_n, o_ir5_c, o_ir5_i,
    // adder
    output logic o_sb_add, o_db_add, o_db_n_add, o_0_add,
    output logic o_1_addc, o_sums, o_srs, o_acr_c
);
    logic known;
    logic cls_incdec, cls_shift, cls_flag, cls_load_imm;
    logic cls_abs, abs_store, cls_xfer;
    logic src_x, src_y, src_ac, src_s;
    logic dst_x, dst_y, dst_ac, dst_s;
    logic sets_nz, dec, shift_right, rotate, flag_i;

    opcode_classifier u_classifier (
        .i_ir           (i_ir),
        .o_known        (known),
        .o_cls_incdec   (cls_incdec),
        .o_cls_shift    (cls_shift),
        .o_cls_flag     (cls_flag),
        .o_cls_load_imm (cls_load_imm),
        .o_cls_abs      (cls_abs),
        .o_abs_store    (abs_store),
        .o_cls_xfer     (cls_xfer),
        // NOP only counts toward o_known
        .o_cls_nop      (),
        .o_src_x        (src_x),
        .o_src_y        (src_y),
        .o_src_ac       (src_ac),
        .o_src_s        (src_s),
        .o_dst_x        (dst_x),
        .o_dst_y        (dst_y),
        .o_dst_ac       (dst_ac),
        .o_dst_s        (dst_s),
        .o_sets_nz      (sets_nz),
        .o_dec          (dec),
        .o_shift_right  (shift_right),
        .o_rotate       (rotate),
        .o_flag_i       (flag_i)
    );

    timing_counter u_timing (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_known   (known),
        .i_cls_abs (cls_abs),
        .o_tcu     (o_tcu)
    );

    // strobe outputs connect by name
    address_bus_control u_addr (
        .i_tcu          (o_tcu),
        .i_known        (known),
        .i_cls_load_imm (cls_load_imm),
        .i_cls_abs      (cls_abs),
        .i_abs_store    (abs_store),
        .*
    );

    register_bus_control u_regs (
        .i_tcu          (o_tcu),
        .i_cls_incdec   (cls_incdec),
        .i_cls_shift    (cls_shift),
        .i_cls_flag     (cls_flag),
        .i_cls_load_imm (cls_load_imm),
        .i_cls_xfer     (cls_xfer),
        .i_cls_abs      (cls_abs),
        .i_abs_store    (abs_store),
        .i_src_x        (src_x),
        .i_src_y        (src_y),
        .i_src_ac       (src_ac),
        .i_src_s        (src_s),
        .i_dst_x        (dst_x),
        .i_dst_y        (dst_y),
        .i_dst_ac       (dst_ac),
        .i_dst_s        (dst_s),
        .i_sets_nz      (sets_nz),
        .i_shift_right  (shift_right),
        .i_flag_i       (flag_i),
        .*
    );

    alu_control u_alu (
        .i_tcu         (o_tcu),
        .i_p           (i_p),
        .i_cls_incdec  (cls_incdec),
        .i_cls_shift   (cls_shift),
        .i_cls_abs     (cls_abs),
        .i_dec         (dec),
        .i_shift_right (shift_right),
        .i_rotate      (rotate),
        .*
    );

endmodule

/* verification/decode_rom_tb.sv */
/*
 * Random opcode stream against a reference model of the decode rules.
 * A new opcode is applied 2 ns after each edge that enters T1.
 * A new P byte is applied 2 ns after every edge.
 * Concurrent assertions compare the state and every strobe each cycle.
 */
`timescale 1ns/100ps

module decode_rom_tb
    import mos6502_isa_pkg::*;
    import mos6502_timing_pkg::*;
();
    localparam int SEED        = 83800;
    localparam int NUM_INSTR   = 300;
    // 300 instructions of 2 to 4 cycles, plus 16 cycles per unknown opcode
    localparam int CYCLE_LIMIT = 1500;

    // one-hot instruction kinds, in descriptor field order
    localparam logic [6:0] K_INCDEC = 7'b1000000;
    localparam logic [6:0] K_SHIFT  = 7'b0100000;
    localparam logic [6:0] K_FLAG   = 7'b0010000;
    localparam logic [6:0] K_LDIMM  = 7'b0001000;
    localparam logic [6:0] K_ABS    = 7'b0000100;
    localparam logic [6:0] K_XFER   = 7'b0000010;
    localparam logic [6:0] K_NOP    = 7'b0000001;

    // register selects as {s, ac, y, x}
    localparam logic [3:0] R_NONE = 4'b0000;
    localparam logic [3:0] R_X    = 4'b0001;
    localparam logic [3:0] R_Y    = 4'b0010;
    localparam logic [3:0] R_AC   = 4'b0100;
    localparam logic [3:0] R_S    = 4'b1000;

    // stack opcodes are outside the decoded set
    localparam logic [7:0] DROPPED_OPS [4] = '{8'h08, 8'h28, 8'h48, 8'h68};

    // alt marks decrement, right shift or the I flag
    typedef struct packed {
        logic       incdec, shift, flag, ldimm, absolute, xfer, nop;
        logic       store, alt, rot;
        logic [3:0] src, dst;
    } op_desc_t;

    logic             i_clk, i_arst_n;
    logic [7:0]       i_ir, i_p;
    logic [TCU_W-1:0] o_tcu;
    logic o_pcl_adl, o_pch_adh, o_adl_abl, o_adh_abh;
    logic o_pcl_pcl, o_pch_pch, o_i_pc, o_add_adl, o_dl_adh, o_rw;
    logic o_x_sb, o_y_sb, o_ac_sb, o_s_sb, o_sb_x, o_sb_y, o_sb_ac, o_sb_s;
    logic o_sb_db, o_dl_db, o_ac_db, o_add_sb_7, o_add_sb_0_6;
    logic o_dbz_z, o_db7_n, o_ir5_c, o_ir5_i;
    logic o_sb_add, o_db_add, o_db_n_add, o_0_add, o_1_addc, o_sums, o_srs, o_acr_c;

    op_desc_t         desc;
    logic [TCU_W-1:0] exp_tcu;
    logic             known, t0, t1, t2, abs_t3, pc_bus;
    logic             write_back, abs_load, src_drive, dst_load, zn_load;
    logic [9:0]       exp_addr, act_addr;
    logic [16:0]      exp_regs, act_regs;
    logic [7:0]       exp_alu, act_alu;
    int               cycle_count = 0;

    decode_rom_top UUT (.*);

    // descriptor is {kind, store, alt, rot, src, dst}
    function automatic op_desc_t describe_opcode(input logic [7:0] op);
        case (op)
            OP_INX:     describe_opcode = {K_INCDEC, 3'b000, R_X, R_X};
            OP_INY:     describe_opcode = {K_INCDEC, 3'b000, R_Y, R_Y};
            OP_DEX:     describe_opcode = {K_INCDEC, 3'b010, R_X, R_X};
            OP_DEY:     describe_opcode = {K_INCDEC, 3'b010, R_Y, R_Y};
            OP_ASL_A:   describe_opcode = {K_SHIFT, 3'b000, R_AC, R_AC};
            OP_ROL_A:   describe_opcode = {K_SHIFT, 3'b001, R_AC, R_AC};
            OP_LSR_A:   describe_opcode = {K_SHIFT, 3'b010, R_AC, R_AC};
            OP_ROR_A:   describe_opcode = {K_SHIFT, 3'b011, R_AC, R_AC};
            OP_CLC:     describe_opcode = {K_FLAG, 3'b000, R_NONE, R_NONE};
            OP_SEC:     describe_opcode = {K_FLAG, 3'b000, R_NONE, R_NONE};
            OP_CLI:     describe_opcode = {K_FLAG, 3'b010, R_NONE, R_NONE};
            OP_SEI:     describe_opcode = {K_FLAG, 3'b010, R_NONE, R_NONE};
            OP_TAX:     describe_opcode = {K_XFER, 3'b000, R_AC, R_X};
            OP_TAY:     describe_opcode = {K_XFER, 3'b000, R_AC, R_Y};
            OP_TXA:     describe_opcode = {K_XFER, 3'b000, R_X, R_AC};
            OP_TYA:     describe_opcode = {K_XFER, 3'b000, R_Y, R_AC};
            OP_TXS:     describe_opcode = {K_XFER, 3'b000, R_X, R_S};
            OP_TSX:     describe_opcode = {K_XFER, 3'b000, R_S, R_X};
            OP_NOP:     describe_opcode = {K_NOP, 3'b000, R_NONE, R_NONE};
            OP_LDA_IMM: describe_opcode = {K_LDIMM, 3'b000, R_NONE, R_AC};
            OP_LDX_IMM: describe_opcode = {K_LDIMM, 3'b000, R_NONE, R_X};
            OP_LDY_IMM: describe_opcode = {K_LDIMM, 3'b000, R_NONE, R_Y};
            OP_LDA_ABS: describe_opcode = {K_ABS, 3'b000, R_NONE, R_AC};
            OP_LDX_ABS: describe_opcode = {K_ABS, 3'b000, R_NONE, R_X};
            OP_LDY_ABS: describe_opcode = {K_ABS, 3'b000, R_NONE, R_Y};
            OP_STA_ABS: describe_opcode = {K_ABS, 3'b100, R_AC, R_NONE};
            default:    describe_opcode = '0;
        endcase
    endfunction

    // mostly decoded opcodes, now and then a dropped one
    function automatic logic [7:0] random_opcode();
        logic [7:0] op;
        if ($urandom_range(31) == 0)
        begin
            op = DROPPED_OPS[2'($urandom_range(3))];
        end
        else
        begin
            do
                op = 8'($urandom);
            while (describe_opcode(op) == '0);
        end
        return op;
    endfunction

    task automatic abort_with_failure(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    // expected timing state
    always @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            exp_tcu <= T0;
        else if ((desc.absolute && (exp_tcu == T3))
                 || (known && !desc.absolute && (exp_tcu == T1)))
            exp_tcu <= T0;
        else
            exp_tcu <= exp_tcu + TCU_W'(1);
    end

    // expected strobes for the current state, opcode and P
    always_comb
    begin
        desc   = describe_opcode(i_ir);
        known  = |{desc.incdec, desc.shift, desc.flag, desc.ldimm, desc.absolute,
                   desc.xfer, desc.nop};
        t0     = (exp_tcu == T0);
        t1     = (exp_tcu == T1);
        t2     = (exp_tcu == T2);
        abs_t3 = desc.absolute && (exp_tcu == T3);
        pc_bus = t0 || (known && (t1 || t2));

        exp_addr = {pc_bus, pc_bus, pc_bus || abs_t3, pc_bus || abs_t3,
                    pc_bus || abs_t3, pc_bus || abs_t3,
                    t0 || (t1 && (desc.ldimm || desc.absolute)) || abs_t3,
                    abs_t3, abs_t3, (abs_t3 && desc.store) ? RW_WRITE : RW_READ};

        // adder result of the finished instruction is written back at T0
        write_back = t0 && (desc.incdec || desc.shift);
        abs_load   = abs_t3 && !desc.store;
        src_drive  = t1 && (desc.incdec || desc.shift || desc.xfer);
        dst_load   = write_back || (t1 && (desc.xfer || desc.ldimm)) || abs_load;
        zn_load    = write_back || abs_load
                  || (t1 && (desc.ldimm || (desc.xfer && (i_ir != OP_TXS))));
        exp_regs   = {src_drive ? desc.src : R_NONE, dst_load ? desc.dst : R_NONE,
                      zn_load || (t1 && desc.shift && !desc.alt),
                      (t1 && (desc.ldimm || desc.absolute)) || abs_load,
                      abs_t3 && desc.store,
                      write_back || (t2 && desc.absolute),
                      write_back || (t2 && desc.absolute),
                      zn_load, zn_load,
                      t1 && desc.flag && !desc.alt, t1 && desc.flag && desc.alt};

        // {sb_add, db_add, db_n_add, 0_add, 1_addc, sums, srs, acr_c}
        exp_alu = 8'b0000_0000;
        if (t1 && desc.incdec)
            exp_alu = desc.alt ? 8'b1100_0100 : 8'b1010_1100;
        else if (t1 && desc.shift)
            exp_alu = (desc.alt ? 8'b1000_0011 : 8'b1100_0101)
                    | {4'b0000, desc.rot && i_p[P_CARRY], 3'b000};
        else if (t1 && desc.absolute)
            exp_alu = 8'b0101_0100;
        else if (t2 && desc.absolute)
            exp_alu = 8'b1010_0100;
    end

    assign act_addr = {o_pcl_adl, o_pch_adh, o_adl_abl, o_adh_abh, o_pcl_pcl, o_pch_pch,
                       o_i_pc, o_add_adl, o_dl_adh, o_rw};
    assign act_regs = {o_s_sb, o_ac_sb, o_y_sb, o_x_sb, o_sb_s, o_sb_ac, o_sb_y, o_sb_x,
                       o_sb_db, o_dl_db, o_ac_db, o_add_sb_7, o_add_sb_0_6,
                       o_dbz_z, o_db7_n, o_ir5_c, o_ir5_i};
    assign act_alu  = {o_sb_add, o_db_add, o_db_n_add, o_0_add, o_1_addc, o_sums, o_srs, o_acr_c};

    assert property (@(posedge i_clk) $rose(i_arst_n) |-> (o_tcu == T0) && (o_rw == RW_READ))
        else abort_with_failure($sformatf("Mismatch at %0t: not T0 and read after reset", $time));

    assert property (@(posedge i_clk) disable iff (!i_arst_n) o_tcu == exp_tcu)
        else abort_with_failure($sformatf("Mismatch at %0t: state %0d, expected %0d, opcode %h",
                                          $time, $sampled(o_tcu), $sampled(exp_tcu),
                                          $sampled(i_ir)));

    assert property (@(posedge i_clk) disable iff (!i_arst_n) act_addr == exp_addr)
        else abort_with_failure($sformatf("Mismatch at %0t: address strobes %b, expected %b",
                                          $time, $sampled(act_addr), $sampled(exp_addr)));

    assert property (@(posedge i_clk) disable iff (!i_arst_n) act_regs == exp_regs)
        else abort_with_failure($sformatf("Mismatch at %0t: register strobes %b, expected %b",
                                          $time, $sampled(act_regs), $sampled(exp_regs)));

    assert property (@(posedge i_clk) disable iff (!i_arst_n) act_alu == exp_alu)
        else abort_with_failure($sformatf("Mismatch at %0t: adder strobes %b, expected %b",
                                          $time, $sampled(act_alu), $sampled(exp_alu)));

    initial
    begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    always @(posedge i_clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
            abort_with_failure($sformatf("timeout: run not finished after %0d cycles",
                                         CYCLE_LIMIT));
    end

    initial
    begin
        void'($urandom(SEED));
        i_arst_n = 1'b0;
        i_ir     = OP_NOP;
        i_p      = 8'h00;
        repeat (5) @(posedge i_clk);
        #2;
        i_arst_n = 1'b1;
        repeat (NUM_INSTR)
        begin
            // new P every cycle, new opcode once the state enters T1
            do
            begin
                @(posedge i_clk);
                #2;
                i_p = 8'($urandom);
            end
            while (exp_tcu != T1);
            i_ir = random_opcode();
        end
        // last instruction finishes and its T0 cycle gets checked
        do
        begin
            @(posedge i_clk);
            #2;
        end
        while (exp_tcu != T0);
        @(posedge i_clk);
        #1;
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* vlog.f */
src/mos6502_isa_pkg.sv
src/mos6502_timing_pkg.sv
src/opcode_classifier.sv
src/timing_counter.sv
src/address_bus_control.sv
src/register_bus_control.sv
src/alu_control.sv
src/decode_rom_top.sv
verification/decode_rom_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= decode_rom_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= CHECKS FAILED
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --assert --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	-./$(OBJ_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no pass message in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
